//--- verilog/rv32_isa_pkg.sv
`default_nettype none

package rv32_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // the encoding follows funct3 of the OP and OP-IMM opcodes
    typedef enum logic [2:0] {
        alu_add  = 3'b000,
        alu_sll  = 3'b001,
        alu_slt  = 3'b010,
        alu_sltu = 3'b011,
        alu_xor  = 3'b100,
        alu_srl  = 3'b101,
        alu_or   = 3'b110,
        alu_and  = 3'b111
    } alu_op_t;

    typedef enum logic [1:0] {
        alu_src1_rs1  = 2'b00,
        alu_src1_pc   = 2'b01,
        alu_src1_zero = 2'b10
    } alu_src1_t;

    typedef enum logic [1:0] {
        alu_src2_rs2  = 2'b00,
        alu_src2_imm  = 2'b01,
        alu_src2_four = 2'b10
    } alu_src2_t;

    // the condition is tested on the ALU result, so beq runs a subtract
    // and checks for zero while blt runs slt and checks for non zero
    typedef enum logic [1:0] {
        branch_never    = 2'b00,
        branch_zero     = 2'b01,
        branch_non_zero = 2'b10,
        branch_always   = 2'b11
    } branch_op_t;

endpackage

`default_nettype wire

//--- verilog/rv32_pipe_pkg.sv
`default_nettype none

package rv32_pipe_pkg;

    // decoded instruction as it arrives on the issue port
    typedef struct packed {
        logic                      valid;
        rv32_isa_pkg::word_t       pc;
        rv32_isa_pkg::reg_addr_t   rs1;
        rv32_isa_pkg::reg_addr_t   rs2;
        rv32_isa_pkg::word_t       imm;
        rv32_isa_pkg::alu_op_t     alu_op;
        logic                      sub_sra;
        rv32_isa_pkg::alu_src1_t   alu_src1;
        rv32_isa_pkg::alu_src2_t   alu_src2;
        rv32_isa_pkg::branch_op_t  branch_op;
        // 0 is pc-relative, 1 is rs1-relative (jalr)
        logic                      pc_src;
        logic                      predicted_taken;
        rv32_isa_pkg::reg_addr_t   rd;
        logic                      rd_write;
    } issue_t;

    typedef struct packed {
        logic                      valid;
        rv32_isa_pkg::word_t       pc;
        rv32_isa_pkg::word_t       result;
        rv32_isa_pkg::branch_op_t  branch_op;
        rv32_isa_pkg::word_t       branch_pc;
        logic                      misaligned;
        logic                      predicted_taken;
        rv32_isa_pkg::reg_addr_t   rd;
        logic                      rd_write;
    } exec_t;

    typedef struct packed {
        logic                      valid;
        rv32_isa_pkg::word_t       pc;
        rv32_isa_pkg::reg_addr_t   rd;
        logic                      rd_write;
        rv32_isa_pkg::word_t       value;
        logic                      taken;
        rv32_isa_pkg::word_t       next_pc;
        logic                      mispredict;
        logic                      misaligned;
    } retire_t;

    typedef struct packed {
        logic                      en;
        rv32_isa_pkg::reg_addr_t   addr;
        rv32_isa_pkg::word_t       data;
    } reg_write_t;

endpackage

`default_nettype wire

//--- verilog/rv32_alu.sv
`timescale 1ns/100ps
`default_nettype none

module rv32_alu (
    input  var rv32_isa_pkg::alu_op_t   op,
    input  wire logic                   sub_sra,
    input  var rv32_isa_pkg::alu_src1_t src1,
    input  var rv32_isa_pkg::alu_src2_t src2,
    input  var rv32_isa_pkg::word_t     pc,
    input  var rv32_isa_pkg::word_t     rs1_value,
    input  var rv32_isa_pkg::word_t     rs2_value,
    input  var rv32_isa_pkg::word_t     imm,
    output rv32_isa_pkg::word_t         result
);
    rv32_isa_pkg::word_t op1;
    rv32_isa_pkg::word_t op2;
    logic [4:0]          shamt;

    always_comb begin
        case (src1)
            rv32_isa_pkg::alu_src1_rs1: op1 = rs1_value;
            rv32_isa_pkg::alu_src1_pc:  op1 = pc;
            default:                    op1 = '0;
        endcase

        case (src2)
            rv32_isa_pkg::alu_src2_rs2: op2 = rs2_value;
            rv32_isa_pkg::alu_src2_imm: op2 = imm;
            default:                    op2 = 32'd4;
        endcase
    end

    assign shamt = op2[4:0];

    always_comb begin
        case (op)
            rv32_isa_pkg::alu_add:  result = sub_sra ? op1 - op2 : op1 + op2;
            rv32_isa_pkg::alu_sll:  result = op1 << shamt;
            rv32_isa_pkg::alu_slt:  result = {31'b0, $signed(op1) < $signed(op2)};
            rv32_isa_pkg::alu_sltu: result = {31'b0, op1 < op2};
            rv32_isa_pkg::alu_xor:  result = op1 ^ op2;
            rv32_isa_pkg::alu_srl: begin
                if (sub_sra)
                    result = $signed(op1) >>> shamt;
                else
                    result = op1 >> shamt;
            end
            rv32_isa_pkg::alu_or:   result = op1 | op2;
            default:                result = op1 & op2;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/rv32_branch_target.sv
`timescale 1ns/100ps
`default_nettype none

module rv32_branch_target (
    input  wire logic               pc_src,
    input  var rv32_isa_pkg::word_t pc,
    input  var rv32_isa_pkg::word_t rs1_value,
    input  var rv32_isa_pkg::word_t imm,
    output rv32_isa_pkg::word_t     target,
    output logic                    misaligned
);
    rv32_isa_pkg::word_t base;
    rv32_isa_pkg::word_t sum;

    assign base = pc_src ? rs1_value : pc;
    assign sum  = base + imm;

    // jalr drops bit 0 of the sum, the pc-relative forms keep it as is
    assign target = {sum[31:1], sum[0] & ~pc_src};

    // without the C extension every target has to sit on a word boundary
    assign misaligned = target[1];

endmodule

`default_nettype wire

//--- verilog/rv32_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module rv32_regfile (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  var rv32_pipe_pkg::reg_write_t write,
    input  var rv32_isa_pkg::reg_addr_t  rs1,
    input  var rv32_isa_pkg::reg_addr_t  rs2,
    output rv32_isa_pkg::word_t          rs1_value,
    output rv32_isa_pkg::word_t          rs2_value
);
    // x0 has no storage
    rv32_isa_pkg::word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write.en && write.addr != '0) begin
            regs[write.addr] <= write.data;
        end
    end

    // reads see the old value during a write, the execute bypass covers that case
    assign rs1_value = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_value = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- verilog/rv32_execute.sv
`timescale 1ns/100ps
`default_nettype none

module rv32_execute (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     stall,
    input  wire logic                     flush,
    input  var rv32_pipe_pkg::issue_t     issue,
    input  var rv32_isa_pkg::word_t       rs1_value,
    input  var rv32_isa_pkg::word_t       rs2_value,
    input  var rv32_pipe_pkg::reg_write_t writeback,
    output rv32_pipe_pkg::exec_t          exec
);
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operand bypass
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the execute slot holds the newest result and wins over the writeback port
    function automatic rv32_isa_pkg::word_t forward(
        input rv32_isa_pkg::reg_addr_t   src,
        input rv32_isa_pkg::word_t       rf_value,
        input rv32_pipe_pkg::exec_t      ex,
        input rv32_pipe_pkg::reg_write_t wb
    );
        if (src != '0 && ex.valid && ex.rd_write && ex.rd == src)
            return ex.result;
        else if (src != '0 && wb.en && wb.addr == src)
            return wb.data;
        else
            return rf_value;
    endfunction

    rv32_isa_pkg::word_t rs1_fwd;
    rv32_isa_pkg::word_t rs2_fwd;

    assign rs1_fwd = forward(issue.rs1, rs1_value, exec, writeback);
    assign rs2_fwd = forward(issue.rs2, rs2_value, exec, writeback);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU and branch target
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    rv32_isa_pkg::word_t alu_result;
    rv32_isa_pkg::word_t branch_pc;
    logic                branch_misaligned;

    rv32_alu alu (
        .op        (issue.alu_op),
        .sub_sra   (issue.sub_sra),
        .src1      (issue.alu_src1),
        .src2      (issue.alu_src2),
        .pc        (issue.pc),
        .rs1_value (rs1_fwd),
        .rs2_value (rs2_fwd),
        .imm       (issue.imm),
        .result    (alu_result)
    );

    rv32_branch_target branch_target (
        .pc_src     (issue.pc_src),
        .pc         (issue.pc),
        .rs1_value  (rs1_fwd),
        .imm        (issue.imm),
        .target     (branch_pc),
        .misaligned (branch_misaligned)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // execute pipeline register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!stall) begin
            exec.valid           <= issue.valid;
            exec.pc              <= issue.pc;
            exec.result          <= alu_result;
            exec.branch_pc       <= branch_pc;
            exec.misaligned      <= branch_misaligned;
            exec.predicted_taken <= issue.predicted_taken;
            exec.rd              <= issue.rd;

            // an empty issue slot must not write or branch whatever its fields say
            // a jump to a misaligned target never links and so is never forwarded
            exec.rd_write  <= issue.valid && issue.rd_write &&
                              !(issue.branch_op == rv32_isa_pkg::branch_always &&
                                branch_misaligned);
            exec.branch_op <= issue.valid ? issue.branch_op : rv32_isa_pkg::branch_never;

            if (flush) begin
                exec.valid     <= 1'b0;
                exec.rd_write  <= 1'b0;
                exec.branch_op <= rv32_isa_pkg::branch_never;
            end
        end

        if (reset) begin
            exec.valid     <= 1'b0;
            exec.rd_write  <= 1'b0;
            exec.branch_op <= rv32_isa_pkg::branch_never;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rv32_retire.sv
`timescale 1ns/100ps
`default_nettype none

module rv32_retire (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 stall,
    input  var rv32_pipe_pkg::exec_t  exec,
    output rv32_pipe_pkg::retire_t    retire,
    output rv32_pipe_pkg::reg_write_t reg_write
);
    logic                taken;
    logic                live;
    logic                write_ok;
    rv32_isa_pkg::word_t next_pc;

    always_comb begin
        case (exec.branch_op)
            rv32_isa_pkg::branch_zero:     taken = (exec.result == '0);
            rv32_isa_pkg::branch_non_zero: taken = (exec.result != '0);
            rv32_isa_pkg::branch_always:   taken = 1'b1;
            default:                       taken = 1'b0;
        endcase
    end

    assign next_pc = taken ? exec.branch_pc : exec.pc + 32'd4;

    // a stalled execute slot is held upstream and retires once it is released
    assign live = exec.valid && !stall;

    // a taken jump to a misaligned target does not link
    assign write_ok = live && exec.rd_write && !(taken && exec.misaligned);

    always_ff @(posedge clk) begin
        retire.valid      <= live;
        retire.pc         <= exec.pc;
        retire.rd         <= exec.rd;
        retire.rd_write   <= write_ok;
        retire.value      <= exec.result;
        retire.taken      <= live && taken;
        retire.next_pc    <= next_pc;
        retire.mispredict <= live && (taken != exec.predicted_taken);
        retire.misaligned <= live && taken && exec.misaligned;

        reg_write.en   <= write_ok;
        reg_write.addr <= exec.rd;
        reg_write.data <= exec.result;

        if (reset) begin
            retire.valid      <= 1'b0;
            retire.rd_write   <= 1'b0;
            retire.taken      <= 1'b0;
            retire.mispredict <= 1'b0;
            retire.misaligned <= 1'b0;
            reg_write.en      <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rv32_exec_core.sv
`timescale 1ns/100ps
`default_nettype none

module rv32_exec_core (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 stall,
    input  wire logic                 flush,
    input  var rv32_pipe_pkg::issue_t issue,
    output rv32_pipe_pkg::retire_t    retire
);
    rv32_isa_pkg::word_t       rs1_value;
    rv32_isa_pkg::word_t       rs2_value;
    rv32_pipe_pkg::exec_t      exec;
    rv32_pipe_pkg::reg_write_t reg_write;

    rv32_regfile regfile (
        .clk       (clk),
        .reset     (reset),
        .write     (reg_write),
        .rs1       (issue.rs1),
        .rs2       (issue.rs2),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    // the retire write port doubles as the second bypass source
    rv32_execute execute (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .flush     (flush),
        .issue     (issue),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .writeback (reg_write),
        .exec      (exec)
    );

    rv32_retire retire_stage (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .exec      (exec),
        .retire    (retire),
        .reg_write (reg_write)
    );

endmodule

`default_nettype wire

//--- tests/rv32_exec_checker.sv
`timescale 1ns/100ps
`default_nettype none

module rv32_exec_checker (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  var rv32_pipe_pkg::retire_t retire
);
    int fail_count = 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // retire port rules
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // both pipeline registers are empty right after reset
    quiet_after_reset: assert property (
        @(posedge clk) $fell(reset) |-> !retire.valid ##1 !retire.valid
    ) else begin
        fail_count++;
        $error("retire valid within two cycles of reset");
    end

    no_stray_mispredict: assert property (
        @(posedge clk) disable iff (reset) !retire.valid |-> !retire.mispredict
    ) else begin
        fail_count++;
        $error("mispredict high on an empty retire slot");
    end

    aligned_next_pc: assert property (
        @(posedge clk) disable iff (reset)
            (retire.valid && !retire.misaligned) |-> retire.next_pc[1:0] == 2'b00
    ) else begin
        fail_count++;
        $error("next_pc not word aligned");
    end

endmodule

bind rv32_exec_core rv32_exec_checker i_checker (
    .clk    (clk),
    .reset  (reset),
    .retire (retire)
);

`default_nettype wire

//--- tests/rv32_exec_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rv32_exec_tb;

    logic                   clk;
    logic                   reset;
    logic                   stall;
    logic                   flush;
    rv32_pipe_pkg::issue_t  issue;
    rv32_pipe_pkg::retire_t retire;

    rv32_exec_core i_dut (
        .clk    (clk),
        .reset  (reset),
        .stall  (stall),
        .flush  (flush),
        .issue  (issue),
        .retire (retire)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    rv32_isa_pkg::word_t    arch [0:31];
    rv32_pipe_pkg::retire_t exp_q [$];
    bit                     ready_q [$];
    rv32_pipe_pkg::retire_t pending_rec;
    bit                     pending;
    bit                     last_stall;
    rv32_isa_pkg::word_t    pc;
    int                     errors;
    int                     accepted;
    int                     retired;

    function automatic rv32_isa_pkg::word_t alu_model(rv32_isa_pkg::alu_op_t op, logic alt,
                                                      rv32_isa_pkg::word_t a,
                                                      rv32_isa_pkg::word_t b);
        case (op)
            rv32_isa_pkg::alu_add:  return alt ? a - b : a + b;
            rv32_isa_pkg::alu_sll:  return a << b[4:0];
            rv32_isa_pkg::alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rv32_isa_pkg::alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            rv32_isa_pkg::alu_xor:  return a ^ b;
            rv32_isa_pkg::alu_srl: begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                else
                    return a >> b[4:0];
            end
            rv32_isa_pkg::alu_or:   return a | b;
            default:                return a & b;
        endcase
    endfunction

    // builds the retire record and commits the write to the architectural state
    function automatic rv32_pipe_pkg::retire_t expect_record(rv32_pipe_pkg::issue_t ins);
        rv32_pipe_pkg::retire_t r;
        rv32_isa_pkg::word_t    a1;
        rv32_isa_pkg::word_t    a2;
        rv32_isa_pkg::word_t    op1;
        rv32_isa_pkg::word_t    op2;
        rv32_isa_pkg::word_t    target;
        logic                   taken;
        a1 = (ins.rs1 == 5'd0) ? 32'd0 : arch[ins.rs1];
        a2 = (ins.rs2 == 5'd0) ? 32'd0 : arch[ins.rs2];
        op1 = (ins.alu_src1 == rv32_isa_pkg::alu_src1_rs1) ? a1 :
              (ins.alu_src1 == rv32_isa_pkg::alu_src1_pc) ? ins.pc : 32'd0;
        op2 = (ins.alu_src2 == rv32_isa_pkg::alu_src2_rs2) ? a2 :
              (ins.alu_src2 == rv32_isa_pkg::alu_src2_imm) ? ins.imm : 32'd4;
        r = '0;
        r.value = alu_model(ins.alu_op, ins.sub_sra, op1, op2);
        target = (ins.pc_src ? a1 : ins.pc) + ins.imm;
        if (ins.pc_src)
            target[0] = 1'b0;
        case (ins.branch_op)
            rv32_isa_pkg::branch_zero:     taken = (r.value == 32'd0);
            rv32_isa_pkg::branch_non_zero: taken = (r.value != 32'd0);
            rv32_isa_pkg::branch_always:   taken = 1'b1;
            default:                       taken = 1'b0;
        endcase
        r.valid = 1'b1;
        r.pc = ins.pc;
        r.rd = ins.rd;
        r.taken = taken;
        r.misaligned = taken && target[1];
        r.rd_write = ins.rd_write && !r.misaligned;
        r.next_pc = taken ? target : ins.pc + 32'd4;
        r.mispredict = (taken != ins.predicted_taken);
        if (r.rd_write && ins.rd != 5'd0)
            arch[ins.rd] = r.value;
        return r;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // registers come from x0..x7 so that dependences are frequent
    function automatic rv32_pipe_pkg::issue_t random_instr(rv32_isa_pkg::word_t at);
        rv32_pipe_pkg::issue_t ins;
        int                    kind;
        ins = '0;
        kind = int'($urandom_range(0, 9));
        ins.valid = (kind != 0);
        ins.pc = at;
        ins.rs1 = 5'($urandom_range(0, 7));
        ins.rs2 = 5'($urandom_range(0, 7));
        ins.rd = 5'($urandom_range(0, 7));
        ins.imm = ($urandom_range(0, 3) == 0) ? $urandom : $urandom_range(0, 63) - 32'd32;
        ins.alu_op = rv32_isa_pkg::alu_op_t'(3'($urandom_range(0, 7)));
        ins.sub_sra = 1'($urandom_range(0, 1)) &&
                      (ins.alu_op == rv32_isa_pkg::alu_add || ins.alu_op == rv32_isa_pkg::alu_srl);
        ins.alu_src1 = rv32_isa_pkg::alu_src1_rs1;
        ins.alu_src2 = (kind <= 3) ? rv32_isa_pkg::alu_src2_rs2 : rv32_isa_pkg::alu_src2_imm;
        ins.branch_op = rv32_isa_pkg::branch_never;
        ins.predicted_taken = 1'($urandom_range(0, 1));
        ins.rd_write = 1'b1;
        if (kind >= 6) begin
            // one target in four lands on a half-word boundary
            ins.imm = ($urandom_range(0, 127) - 32'd64) * 32'd4;
            if ($urandom_range(0, 3) == 0)
                ins.imm = ins.imm + 32'd2;
        end
        if (kind == 6 || kind == 7) begin
            ins.alu_src2 = rv32_isa_pkg::alu_src2_rs2;
            ins.alu_op = ($urandom_range(0, 1) == 0) ? rv32_isa_pkg::alu_add :
                         ($urandom_range(0, 1) == 0) ? rv32_isa_pkg::alu_slt : rv32_isa_pkg::alu_sltu;
            ins.sub_sra = (ins.alu_op == rv32_isa_pkg::alu_add);
            ins.branch_op = (kind == 6) ? rv32_isa_pkg::branch_zero : rv32_isa_pkg::branch_non_zero;
            ins.rd_write = 1'b0;
        end else if (kind >= 8) begin
            // jal and jalr link pc plus four
            ins.alu_op = rv32_isa_pkg::alu_add;
            ins.sub_sra = 1'b0;
            ins.alu_src1 = rv32_isa_pkg::alu_src1_pc;
            ins.alu_src2 = rv32_isa_pkg::alu_src2_four;
            ins.branch_op = rv32_isa_pkg::branch_always;
            ins.pc_src = (kind == 9);
        end
        return ins;
    endfunction

    task automatic compare_word(string name, rv32_isa_pkg::word_t got, rv32_isa_pkg::word_t exp);
        assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // an instruction shows up after the first unstalled edge past its acceptance
    task automatic check_retire();
        rv32_pipe_pkg::retire_t exp;
        if (!last_stall && ready_q.size() > 0)
            ready_q[0] = 1'b1;
        if (pending) begin
            exp_q.push_back(pending_rec);
            ready_q.push_back(1'b0);
            pending = 1'b0;
        end
        if (ready_q.size() > 0 && ready_q[0]) begin
            exp = exp_q.pop_front();
            void'(ready_q.pop_front());
            retired++;
            assert (retire.valid) else begin
                errors++;
                $display("%0t ns: instruction at pc %h did not retire on time", $time, exp.pc);
            end
            compare_word("retire.pc", retire.pc, exp.pc);
            compare_word("retire.rd", 32'(retire.rd), 32'(exp.rd));
            compare_word("retire.rd_write", 32'(retire.rd_write), 32'(exp.rd_write));
            compare_word("retire.value", retire.value, exp.value);
            compare_word("retire.taken", 32'(retire.taken), 32'(exp.taken));
            compare_word("retire.next_pc", retire.next_pc, exp.next_pc);
            compare_word("retire.mispredict", 32'(retire.mispredict), 32'(exp.mispredict));
            compare_word("retire.misaligned", 32'(retire.misaligned), 32'(exp.misaligned));
        end else begin
            assert (!retire.valid) else begin
                errors++;
                $display("%0t ns: retire valid with no instruction due, pc %h", $time, retire.pc);
            end
        end
    endtask

    task automatic drive_next();
        // the source holds a stalled instruction
        if (!(last_stall && issue.valid)) begin
            issue = random_instr(pc);
            pc = pc + 32'd4;
            if ($urandom_range(0, 15) == 0)
                pc = $urandom & 32'hffff_fffc;
        end
        stall = ($urandom_range(0, 5) == 0);
        flush = ($urandom_range(0, 7) == 0);
        last_stall = stall;
        // a flush with no stall empties the execute slot that this issue would fill
        if (issue.valid && !stall && !flush) begin
            pending_rec = expect_record(issue);
            pending = 1'b1;
            accepted++;
        end
    endtask

    initial begin
        int wait_cycles;
        void'($urandom(32'hfe2d52ca));
        reset = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        issue = '0;
        pc = 32'h0000_1000;
        pending = 1'b0;
        last_stall = 1'b0;
        errors = 0;
        accepted = 0;
        retired = 0;
        for (int i = 0; i < 32; i++) begin
            arch[i] = 32'd0;
        end
        repeat (4) @(negedge clk);
        reset = 1'b0;

        for (int n = 0; n < 3000; n++) begin
            check_retire();
            drive_next();
            @(negedge clk);
        end

        issue.valid = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        wait_cycles = 0;
        while (exp_q.size() > 0 || pending) begin
            check_retire();
            // every edge of the drain runs unstalled
            last_stall = 1'b0;
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > 20) begin
                errors++;
                $display("timed out waiting for %0d instructions to retire", exp_q.size());
                break;
            end
        end
        check_retire();

        $display("accepted %0d, retired %0d, testbench errors %0d, assertion errors %0d",
                 accepted, retired, errors, i_dut.i_checker.fail_count);
        if (errors == 0 && i_dut.i_checker.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
verilog/rv32_isa_pkg.sv
verilog/rv32_pipe_pkg.sv
verilog/rv32_alu.sv
verilog/rv32_branch_target.sv
verilog/rv32_regfile.sv
verilog/rv32_execute.sv
verilog/rv32_retire.sv
verilog/rv32_exec_core.sv
tests/rv32_exec_checker.sv
tests/rv32_exec_tb.sv

//--- Makefile
TOP = rv32_exec_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): build.f verilog/*.sv tests/*.sv
	verilator --binary --timing --assert -f build.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

lint:
	verilator --lint-only -Wall --timing --assert -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir
